/* Bender.yml */
package:
  name: drum_sim

sources:
  - drum_pkg.sv
  - drum_loader.sv
  - drum_node_update.sv
  - drum_column.sv
  - drum_center_tap.sv
  - drum_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_drum_top.sv

/* all.f */
+incdir+.
drum_pkg.sv
drum_loader.sv
drum_node_update.sv
drum_column.sv
drum_center_tap.sv
drum_top.sv
tb_drum_top.sv

/* drum_center_tap.sv */
`default_nettype none

module drum_center_tap (
	input  logic              clk,
	input  logic              rst,
	input  drum_pkg::sample_t center,
	input  logic              trav_end,
	input  drum_pkg::sample_t rho_gain,
	output drum_pkg::sample_t rho_eff,
	output drum_pkg::sample_t sample,
	output logic              sample_valid
);
	import drum_pkg::*;

	// Base tension plus a term that grows with the centre displacement
	function automatic sample_t tension(sample_t gain, sample_t u);
		sample_t            u_s;
		logic signed [35:0] sq_full;
		sample_t            sq;
		logic signed [18:0] sum;
		u_s = u >>> TENSION_SHIFT;
		sq_full = u_s * u_s;
		sq = {sq_full[35], sq_full[33:17]};
		sum = gain + sq;
		if (sum > RHO_MAX) begin
			return RHO_MAX;
		end
		return sum[17:0];
	endfunction

	//////////////////////////////////////////////////
	// Audio sample and tension for the next step
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			sample <= '0;
			sample_valid <= 1'b0;
			rho_eff <= tension(rho_gain, '0);
		end else begin
			sample_valid <= trav_end;
			if (trav_end) begin
				sample <= center;
				rho_eff <= tension(rho_gain, center);
			end
		end
	end

endmodule

`default_nettype wire

/* drum_column.sv */
`default_nettype none

module drum_column #(
	parameter int COL_INDEX = 0
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              run,
	input  logic              load_we,
	input  drum_pkg::load_t   load_wr,
	input  logic              load_done,
	input  drum_pkg::row_t    num_rows,
	input  drum_pkg::sample_t rho,
	input  drum_pkg::sample_t u_left,
	input  drum_pkg::sample_t u_right,
	output drum_pkg::sample_t u_here,
	output drum_pkg::sample_t center,
	output logic              trav_end
);
	import drum_pkg::*;

	// Displacement at step n and step n-1
	sample_t cur_mem [MAX_ROW];
	sample_t prev_mem [MAX_ROW];

	sample_t cur_q;
	sample_t prev_q;
	row_t    cur_ra;
	row_t    prev_ra;
	logic    cur_we;
	logic    prev_we;
	row_t    cur_wa;
	row_t    prev_wa;
	sample_t cur_wd;
	sample_t prev_wd;

	col_state_t state;
	row_t       row;
	row_t       last_row;
	row_t       center_row;
	logic       wrap;
	logic       load_en;

	sample_t u_cur;
	sample_t u_down;
	sample_t bot_new;
	sample_t n_left;
	sample_t n_right;
	sample_t n_up;
	sample_t u_next;

	assign last_row = num_rows - 1'b1;
	assign center_row = num_rows >> 1;
	assign load_en = load_we && !load_done;

	// Clamped membrane edges
	assign n_left = (COL_INDEX == 0) ? '0 : u_left;
	assign n_right = (COL_INDEX == NUM_COL - 1) ? '0 : u_right;
	assign n_up = (row == last_row) ? '0 : cur_q;

	assign u_here = u_cur;

	drum_node_update u_node (
		.u_cur   (u_cur),
		.u_prev  (prev_q),
		.u_left  (n_left),
		.u_right (n_right),
		.u_down  (u_down),
		.u_up    (n_up),
		.rho     (rho),
		.u_next  (u_next)
	);

	//////////////////////////////////////////////////
	// Memories
	//////////////////////////////////////////////////

	// Current memory runs one row ahead of the node
	assign cur_ra = (state == ST_PRIME) ? '0 : row + 1'b1;
	assign prev_ra = row;

	always_comb begin
		cur_we = 1'b0;
		cur_wa = row;
		cur_wd = u_next;
		prev_we = 1'b0;
		prev_wa = row;
		prev_wd = u_cur;
		if (load_en) begin
			// Initial shape goes into both time levels
			cur_we = 1'b1;
			cur_wa = load_wr.row;
			cur_wd = load_wr.data;
			prev_we = 1'b1;
			prev_wa = load_wr.row;
			prev_wd = load_wr.data;
		end else if (state == ST_WRITE) begin
			cur_we = (row != '0);
			prev_we = 1'b1;
		end else if (state == ST_NEXT && wrap) begin
			// Bottom row finally written back
			cur_we = 1'b1;
			cur_wa = '0;
			cur_wd = bot_new;
		end
	end

	always_ff @(posedge clk) begin
		if (cur_we) begin
			cur_mem[cur_wa] <= cur_wd;
		end
		if (prev_we) begin
			prev_mem[prev_wa] <= prev_wd;
		end
		cur_q <= cur_mem[cur_ra];
		prev_q <= prev_mem[prev_ra];
	end

	//////////////////////////////////////////////////
	// Row walk
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			row <= '0;
			wrap <= 1'b0;
			trav_end <= 1'b0;
		end else begin
			trav_end <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (run) begin
						row <= '0;
						state <= ST_PRIME;
					end
				end
				ST_PRIME: state <= ST_NEXT;
				ST_WRITE: state <= ST_SHIFT;
				ST_SHIFT: begin
					if (row == last_row) begin
						wrap <= 1'b1;
					end else begin
						row <= row + 1'b1;
					end
					state <= ST_NEXT;
				end
				ST_NEXT: begin
					if (wrap) begin
						wrap <= 1'b0;
						row <= '0;
						trav_end <= 1'b1;
						state <= ST_IDLE;
					end else begin
						state <= ST_WRITE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Node registers follow the walk
	always_ff @(posedge clk) begin
		case (state)
			ST_PRIME: u_down <= '0;
			ST_NEXT: u_cur <= cur_q;
			ST_WRITE: begin
				if (row == '0) begin
					bot_new <= u_next;
				end
				if (row == center_row) begin
					center <= u_next;
				end
			end
			ST_SHIFT: u_down <= u_cur;
			default: ;
		endcase
	end

	a_state_legal: assert property (
		@(posedge clk) disable iff (rst)
		state inside {ST_IDLE, ST_PRIME, ST_WRITE, ST_SHIFT, ST_NEXT}
	);

	// Top must hold off new steps until the walk is over
	a_run_idle: assert property (
		@(posedge clk) disable iff (rst)
		run |-> state == ST_IDLE
	);

endmodule

`default_nettype wire

/* drum_loader.sv */
`default_nettype none

module drum_loader (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       load_valid,
	input  drum_pkg::load_t            load,
	input  drum_pkg::row_t             num_rows,
	output logic [drum_pkg::NUM_COL-1:0] col_we,
	output drum_pkg::load_t            load_wr,
	output logic                       load_done
);
	import drum_pkg::*;

	// Host write held for the columns
	always_ff @(posedge clk) begin
		if (load_valid) begin
			load_wr <= load;
		end
	end

	//////////////////////////////////////////////////
	// Column select and end of loading
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			col_we <= '0;
			load_done <= 1'b0;
		end else begin
			col_we <= '0;
			if (load_valid) begin
				col_we[load.col] <= 1'b1;
			end
			// Last grid position has just been written
			if (col_we[NUM_COL-1] && load_wr.row == num_rows - 1'b1) begin
				load_done <= 1'b1;
			end
		end
	end

	// Grid is frozen once loading is complete
	a_no_late_load: assert property (
		@(posedge clk) disable iff (rst)
		load_done |-> !load_valid
	);

endmodule

`default_nettype wire

/* drum_node_update.sv */
`default_nettype none

module drum_node_update (
	input  drum_pkg::sample_t u_cur,
	input  drum_pkg::sample_t u_prev,
	input  drum_pkg::sample_t u_left,
	input  drum_pkg::sample_t u_right,
	input  drum_pkg::sample_t u_down,
	input  drum_pkg::sample_t u_up,
	input  drum_pkg::sample_t rho,
	output drum_pkg::sample_t u_next
);
	import drum_pkg::*;

	sample_t            lap;
	logic signed [35:0] prod;
	sample_t            drive;
	sample_t            undamped;

	// Discrete Laplacian around the node
	assign lap = (u_left - u_cur) + (u_right - u_cur)
		+ (u_down - u_cur) + (u_up - u_cur);

	// 1.17 by 1.17 product scaled back to 1.17
	assign prod = lap * rho;
	assign drive = {prod[35], prod[33:17]};

	// Leapfrog step with light damping on the old value
	assign undamped = (u_cur <<< 1) + drive - u_prev + (u_prev >>> DAMP_SHIFT);

	// Global energy loss
	assign u_next = undamped - (undamped >>> DAMP_SHIFT);

endmodule

`default_nettype wire

/* drum_pkg.sv */
`default_nettype none

package drum_pkg;

	//////////////////////////////////////////////////
	// Grid dimensions
	//////////////////////////////////////////////////

	localparam int NUM_COL = 8;
	localparam int MAX_ROW = 32;
	localparam int CENTER_COL = NUM_COL / 2;

	typedef logic [$clog2(MAX_ROW)-1:0] row_t;
	typedef logic [$clog2(NUM_COL)-1:0] col_t;

	//////////////////////////////////////////////////
	// Signed 1.17 fixed point
	//////////////////////////////////////////////////

	typedef logic signed [17:0] sample_t;

	// Tension ceiling of about 0.49
	localparam sample_t RHO_MAX = 18'sh0FAE1;

	// Centre value is scaled down by 2^-4 before squaring
	localparam int TENSION_SHIFT = 4;

	// Damping terms are 2^-10 of the value
	localparam int DAMP_SHIFT = 10;

	// One host write into the initial grid
	typedef struct packed {
		col_t    col;
		row_t    row;
		sample_t data;
	} load_t;

	// Column engine walk
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_PRIME,
		ST_WRITE,
		ST_SHIFT,
		ST_NEXT
	} col_state_t;

endpackage

`default_nettype wire

/* drum_top.sv */
`default_nettype none

module drum_top (
	input  logic              clk,
	input  logic              rst,
	input  logic              load_valid,
	input  drum_pkg::load_t   load,
	input  drum_pkg::row_t    num_rows,
	input  drum_pkg::sample_t rho_gain,
	input  logic              step,
	output logic              load_done,
	output logic              busy,
	output drum_pkg::sample_t sample,
	output logic              sample_valid
);
	import drum_pkg::*;

	logic [NUM_COL-1:0] col_we;
	load_t              load_wr;
	logic               run;
	sample_t            rho_eff;
	sample_t            u_here [NUM_COL];
	sample_t            center [NUM_COL];
	logic [NUM_COL-1:0] trav_end;

	// One step in flight and only on a loaded grid
	assign run = step && load_done && !busy;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
		end else if (run) begin
			busy <= 1'b1;
		end else if (trav_end[CENTER_COL]) begin
			busy <= 1'b0;
		end
	end

	drum_loader u_loader (
		.clk        (clk),
		.rst        (rst),
		.load_valid (load_valid),
		.load       (load),
		.num_rows   (num_rows),
		.col_we     (col_we),
		.load_wr    (load_wr),
		.load_done  (load_done)
	);

	//////////////////////////////////////////////////
	// Column array with neighbours wired as a ring
	//////////////////////////////////////////////////

	for (genvar c = 0; c < NUM_COL; c++) begin : g_col
		drum_column #(
			.COL_INDEX (c)
		) u_col (
			.clk       (clk),
			.rst       (rst),
			.run       (run),
			.load_we   (col_we[c]),
			.load_wr   (load_wr),
			.load_done (load_done),
			.num_rows  (num_rows),
			.rho       (rho_eff),
			.u_left    (u_here[(c + NUM_COL - 1) % NUM_COL]),
			.u_right   (u_here[(c + 1) % NUM_COL]),
			.u_here    (u_here[c]),
			.center    (center[c]),
			.trav_end  (trav_end[c])
		);
	end

	drum_center_tap u_tap (
		.clk          (clk),
		.rst          (rst),
		.center       (center[CENTER_COL]),
		.trav_end     (trav_end[CENTER_COL]),
		.rho_gain     (rho_gain),
		.rho_eff      (rho_eff),
		.sample       (sample),
		.sample_valid (sample_valid)
	);

	// All engines finish on the same cycle
	a_lock_step: assert property (
		@(posedge clk) disable iff (rst)
		trav_end == '0 || trav_end == '1
	);

	a_valid_after_step: assert property (
		@(posedge clk) disable iff (rst)
		sample_valid |-> $past(busy)
	);

endmodule

`default_nettype wire

/* tb_drum_model.svh */
`ifndef TB_DRUM_MODEL_SVH
`define TB_DRUM_MODEL_SVH

//////////////////////////////////////////////////
// Reference membrane with zero edges
//////////////////////////////////////////////////

sample_t     m_cur [NUM_COL][MAX_ROW];
sample_t     m_prev [NUM_COL][MAX_ROW];
sample_t     m_rho;
int          m_rows;
logic [31:0] lcg_state = 32'h25cdc8a2;

// Low 18 bits as a 1.17 value
function automatic sample_t wrap_q17(longint x);
	return sample_t'(x);
endfunction

// Sign of the product above its bits 33 down to 17
function automatic sample_t mul_q17(sample_t a, sample_t b);
	logic [63:0] p;
	p = longint'(a) * longint'(b);
	return {p[63], p[33:17]};
endfunction

// Gain plus square of the scaled centre with an upper clamp
function automatic sample_t tension_of(sample_t gain, sample_t u);
	sample_t scaled;
	longint  sum;
	scaled = u >>> TENSION_SHIFT;
	sum = longint'(gain) + longint'(mul_q17(scaled, scaled));
	if (sum > longint'(RHO_MAX)) begin
		return RHO_MAX;
	end
	return wrap_q17(sum);
endfunction

function automatic sample_t grid_at(int c, int r);
	if (c < 0 || c >= NUM_COL || r < 0 || r >= m_rows) begin
		return '0;
	end
	return m_cur[c][r];
endfunction

function automatic sample_t node_next(int c, int r);
	longint  cur;
	longint  old;
	sample_t lap;
	sample_t undamped;
	cur = grid_at(c, r);
	old = m_prev[c][r];
	lap = wrap_q17(grid_at(c - 1, r) + grid_at(c + 1, r) + grid_at(c, r - 1)
		+ grid_at(c, r + 1) - 4 * cur);
	undamped = wrap_q17(2 * cur + mul_q17(lap, m_rho) - old + (old >>> DAMP_SHIFT));
	return wrap_q17(longint'(undamped) - (longint'(undamped) >>> DAMP_SHIFT));
endfunction

// Whole grid one step ahead, returns the centre node
function automatic sample_t model_step(sample_t gain);
	sample_t nxt [NUM_COL][MAX_ROW];
	sample_t centre;
	int      c;
	int      r;
	for (c = 0; c < NUM_COL; c++) begin
		for (r = 0; r < m_rows; r++) begin
			nxt[c][r] = node_next(c, r);
		end
	end
	m_prev = m_cur;
	m_cur = nxt;
	centre = m_cur[CENTER_COL][m_rows / 2];
	m_rho = tension_of(gain, centre);
	return centre;
endfunction

function automatic logic [31:0] next_random();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// Zero grid or random displacements within about 1/16
function automatic void fill_grid(bit use_random);
	logic [31:0] rnd;
	int          c;
	int          r;
	for (c = 0; c < NUM_COL; c++) begin
		for (r = 0; r < MAX_ROW; r++) begin
			rnd = next_random();
			m_cur[c][r] = use_random ? sample_t'($signed(rnd) >>> 18) : '0;
		end
	end
endfunction

`endif

/* tb_drum_top.sv */
`default_nettype none

module tb_drum_top;
	timeunit 1ns;
	timeprecision 1ps;
	import drum_pkg::*;

	logic    clk;
	logic    rst;
	logic    load_valid;
	load_t   load;
	row_t    num_rows;
	sample_t rho_gain;
	logic    step;
	logic    load_done;
	logic    busy;
	sample_t sample;
	logic    sample_valid;

	sample_t exp_sample;
	logic    pending;
	int      errors;
	int      errors_at_start;
	int      test_num;
	int      tests_passed;
	int      tests_failed;

	`include "tb_drum_model.svh"

	drum_top dut (
		.clk          (clk),
		.rst          (rst),
		.load_valid   (load_valid),
		.load         (load),
		.num_rows     (num_rows),
		.rho_gain     (rho_gain),
		.step         (step),
		.load_done    (load_done),
		.busy         (busy),
		.sample       (sample),
		.sample_valid (sample_valid)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk;
		end
	end

	function automatic void report_mismatch(string name, logic [17:0] got, logic [17:0] want);
		errors++;
		$display("error %s: got %h, expected %h", name, got, want);
	endfunction

	function automatic void report_failure(string what);
		errors++;
		$display("%s", what);
	endfunction

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	a_sample_matches: assert property (@(posedge clk) disable iff (rst)
		sample_valid |-> sample == exp_sample)
	else report_mismatch("sample", $sampled(sample), $sampled(exp_sample));

	// Exactly one pulse per accepted step
	a_valid_only_after_step: assert property (@(posedge clk) disable iff (rst)
		sample_valid |-> pending)
	else report_failure("sample_valid pulsed with no step in flight");

	a_valid_ends_busy: assert property (@(posedge clk) disable iff (rst)
		sample_valid |-> !busy)
	else report_failure("busy still high while sample_valid pulsed");

	a_busy_needs_step: assert property (@(posedge clk) disable iff (rst)
		$rose(busy) |-> $past(step && load_done))
	else report_failure("busy rose without an accepted step");

	a_step_sets_busy: assert property (@(posedge clk) disable iff (rst)
		step && load_done && !busy |=> busy)
	else report_failure("busy stayed low after an accepted step");

	//////////////////////////////////////////////////
	// Stimulus tasks
	//////////////////////////////////////////////////

	task automatic abort_run(string why);
		$display("%s", why);
		$display("tests failed");
		$finish;
	endtask

	// Called on a rising edge or at time zero
	task automatic do_reset(sample_t gain, int rows);
		rst <= 1'b1;
		rho_gain <= gain;
		num_rows <= row_t'(rows);
		step <= 1'b0;
		load_valid <= 1'b0;
		pending <= 1'b0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		m_rows = rows;
		m_rho = tension_of(gain, '0);
	endtask

	// Column by column so the last write is the final grid position
	task automatic load_grid();
		int c;
		int r;
		int n;
		m_prev = m_cur;
		for (c = 0; c < NUM_COL; c++) begin
			for (r = 0; r < m_rows; r++) begin
				@(posedge clk);
				load_valid <= 1'b1;
				load <= '{col: col_t'(c), row: row_t'(r), data: m_cur[c][r]};
			end
		end
		@(posedge clk);
		load_valid <= 1'b0;
		n = 0;
		while (!load_done) begin
			@(posedge clk);
			n++;
			if (n > 8) begin
				abort_run("timeout waiting for load_done");
			end
		end
	endtask

	task automatic run_step(bit strobe_while_busy);
		int n;
		@(posedge clk);
		exp_sample = model_step(rho_gain);
		step <= 1'b1;
		pending <= 1'b1;
		@(posedge clk);
		step <= 1'b0;
		if (strobe_while_busy) begin
			@(posedge clk);
			step <= 1'b1;
			@(posedge clk);
			step <= 1'b0;
		end
		n = 0;
		while (!sample_valid) begin
			@(posedge clk);
			n++;
			if (n > 3 * MAX_ROW + 16) begin
				abort_run("timeout waiting for sample_valid");
			end
		end
		pending <= 1'b0;
	endtask

	task automatic begin_test();
		errors_at_start = errors;
		test_num++;
	endtask

	// One edge more so assertions on the last edge have reported
	task automatic end_test(string name);
		@(posedge clk);
		if (errors == errors_at_start) begin
			tests_passed++;
			$display("test %0d %s: pass", test_num, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: FAIL with %0d errors", test_num, name,
				errors - errors_at_start);
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		rst = 1'b1;
		load_valid = 1'b0;
		load = '0;
		num_rows = row_t'(16);
		rho_gain = '0;
		step = 1'b0;
		pending = 1'b0;
		exp_sample = '0;
		errors = 0;
		test_num = 0;
		tests_passed = 0;
		tests_failed = 0;

		begin_test();
		do_reset(18'sh08000, 16);
		assert (load_done == 1'b0) else report_mismatch("load_done", load_done, '0);
		assert (busy == 1'b0) else report_mismatch("busy", busy, '0);
		assert (sample_valid == 1'b0) else report_mismatch("sample_valid", sample_valid, '0);
		assert (sample == '0) else report_mismatch("sample", sample, '0);
		end_test("reset state");

		begin_test();
		fill_grid(1'b0);
		m_cur[CENTER_COL][8] = 18'sh10000;
		load_grid();
		run_step(1'b0);
		end_test("centred impulse");

		begin_test();
		do_reset(18'sh06000, 16);
		fill_grid(1'b1);
		load_grid();
		repeat (10) run_step(1'b0);
		end_test("random grid, ten steps");

		// Same grid with the gain far above the ceiling
		begin_test();
		@(posedge clk);
		rho_gain <= 18'sh1C000;
		repeat (3) run_step(1'b0);
		assert (dut.rho_eff == RHO_MAX)
		else report_mismatch("rho_eff", dut.rho_eff, RHO_MAX);
		end_test("tension clamp");

		begin_test();
		run_step(1'b1);
		repeat (3 * MAX_ROW + 8) @(posedge clk);
		end_test("step while busy");

		begin_test();
		do_reset(18'sh08000, 8);
		fill_grid(1'b1);
		load_grid();
		repeat (6) run_step(1'b0);
		end_test("eight rows");

		$display("%0d tests run, %0d passed, %0d failed, %0d errors",
			test_num, tests_passed, tests_failed, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
